/* logic/pci_bus_pkg.sv */
// PCI bus protocol constants
package pci_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // field widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int cmd_w   = 4;   // c/be command nibble
  localparam int laddr_w = 2;   // ad[1:0] during address phase

  ////////////////////////////////////////////////////////////////////////////
  // command decode
  ////////////////////////////////////////////////////////////////////////////

  // io read and io write share cmd[3:1]
  localparam logic [cmd_w-2:0] lcmd_io_class = 3'b001;

  localparam int cmd_write_bit = 0;   // cmd[0] set on writes

  ////////////////////////////////////////////////////////////////////////////
  // burst ordering
  ////////////////////////////////////////////////////////////////////////////

  // linear incrementing, all other orders reserved for memory cycles
  localparam logic [laddr_w-1:0] laddr_linear = 2'b00;

endpackage

/* logic/hbi_target_pkg.sv */
// Register target types
package hbi_target_pkg;

  // register block ready machine
  typedef enum logic [2:0] {
    st_idle         = 3'd0,   // waiting for start of burst
    st_wr0          = 3'd1,   // write data phases
    st_rd0          = 3'd2,   // first read, wait for irdy
    st_rd1          = 3'd3,   // read data on bus
    st_rd2          = 3'd4,   // read fetch cycle
    st_wait_frame_h = 3'd5,   // stop held until frame rises
    st_wait_irdy_l  = 3'd6    // disconnect, master not ready yet
  } ready_state_t;

  localparam int addr_w_default = 30;   // word address, ad[31:2]

endpackage

/* logic/bus_phase_detect.sv */
// Bus phase detection
`timescale 1ns/10ps

module bus_phase_detect (
  input  logic hb_clk,            // host bus clock
  input  logic sys_reset_n,
  input  logic frame_n,           // pci frame
  input  logic irdy_n,            // pci initiator ready
  input  logic trdy_n,            // target ready as driven
  input  logic stop_n,            // target stop as driven
  output logic addr_strobe_n,     // address phase, combinational
  output logic sobn_n,            // start of burst, cycle after address
  output logic last_phase,        // final data phase on the bus
  output logic hb_cycle_done_n    // one cycle pulse after last phase
);

  logic frame_d_n;   // frame from previous edge

  ////////////////////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////////////////////

  assign addr_strobe_n = !(!frame_n && frame_d_n);   // frame falling edge

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      frame_d_n <= 1'b1;             // bus idle
      sobn_n    <= 1'b1;
    end else begin
      frame_d_n <= frame_n;
      sobn_n    <= addr_strobe_n;    // start of burst follows strobe
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // end of transaction
  ////////////////////////////////////////////////////////////////////////////

  // master has dropped frame and the phase completes or is stopped
  assign last_phase = frame_n && !irdy_n && (!trdy_n || !stop_n);

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      hb_cycle_done_n <= 1'b1;
    end else begin
      hb_cycle_done_n <= !last_phase;   // done pulse
    end
  end

endmodule

/* logic/target_ready_fsm.sv */
// Register block ready machine
`timescale 1ns/10ps

module target_ready_fsm (
  input  logic                            hb_clk,
  input  logic                            sys_reset_n,
  input  logic                            frame_n,
  input  logic                            irdy_n,
  input  logic                            trdy_n,        // registered ready on bus
  input  logic                            sobn_n,        // start of burst
  input  logic                            cs_regs_n,     // register space
  input  logic                            cs_engine_n,   // engine regs
  input  logic                            cs_kick_n,     // kick reg
  input  logic                            engine_busy,
  input  logic [pci_bus_pkg::laddr_w-1:0] hb_laddr,      // burst order
  input  logic [pci_bus_pkg::cmd_w-1:0]   hb_lcmd,       // latched command
  output logic                            ready_async,   // trdy next cycle
  output logic                            stop_async     // stop next cycle
);

  import pci_bus_pkg::*;
  import hbi_target_pkg::*;

  ready_state_t state;
  ready_state_t next_state;
  logic         hb_write;    // 1 write, 0 read
  logic         burst_cut;   // burst that may not continue
  logic         phase_end;   // last phase taken with data

  assign hb_write  = hb_lcmd[cmd_write_bit];
  assign burst_cut = !frame_n &&
                     ((hb_laddr != laddr_linear) ||             // reserved order
                      (hb_lcmd[cmd_w-1:1] == lcmd_io_class));   // io space
  assign phase_end = frame_n && !irdy_n && !trdy_n;

  ////////////////////////////////////////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ready_async = 1'b0;
    stop_async  = 1'b0;
    next_state  = state;
    if (phase_end) begin
      next_state = st_idle;                   // transaction done
    end else begin
      case (state)
        st_idle: begin
          if (!sobn_n && !cs_regs_n) begin
            if (!hb_write) begin
              next_state = st_rd0;
            end else if (!cs_engine_n && engine_busy) begin
              stop_async = 1'b1;              // retry, no data
              next_state = st_wait_frame_h;
            end else if (!cs_kick_n) begin
              stop_async  = 1'b1;             // disconnect with data
              ready_async = 1'b1;
              next_state  = irdy_n ? st_wait_irdy_l : st_wait_frame_h;
            end else begin
              ready_async = 1'b1;             // normal write
              next_state  = st_wr0;
            end
          end
        end
        st_wr0: begin
          ready_async = 1'b1;
          if (!irdy_n && !trdy_n && burst_cut) begin
            ready_async = 1'b0;               // first phase taken, cut the rest
            stop_async  = 1'b1;
            next_state  = st_wait_frame_h;
          end
        end
        st_rd0: begin
          if (!irdy_n) begin
            ready_async = 1'b1;
            if (burst_cut) begin
              stop_async = 1'b1;              // one read then disconnect
              next_state = st_wait_frame_h;
            end else begin
              next_state = st_rd1;
            end
          end
        end
        st_rd1: begin
          if (!irdy_n) begin
            next_state = st_rd2;              // data taken, fetch next
          end else begin
            ready_async = 1'b1;               // master holding off
          end
        end
        st_rd2: begin
          ready_async = 1'b1;
          next_state  = st_rd1;
        end
        st_wait_frame_h: begin
          if (frame_n) begin
            next_state = st_idle;
          end else begin
            stop_async = 1'b1;
          end
        end
        st_wait_irdy_l: begin
          stop_async = 1'b1;
          if (!irdy_n) begin
            next_state = st_wait_frame_h;     // kick data taken
          end else begin
            ready_async = 1'b1;
          end
        end
        default: next_state = st_idle;
      endcase
    end
  end

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

endmodule

/* logic/bus_response.sv */
// Target bus response
`timescale 1ns/10ps

module bus_response (
  input  logic                          hb_clk,
  input  logic                          sys_reset_n,
  input  logic                          sobn_n,            // start of burst
  input  logic                          last_phase,        // final data phase
  input  logic                          hb_cycle_done_n,   // done pulse
  input  logic                          cs_regs_n,
  input  logic                          ready_async,       // from ready fsm
  input  logic                          stop_async,        // from ready fsm
  input  logic                          irdy_n,
  input  logic [pci_bus_pkg::cmd_w-1:0] hb_lcmd,
  output logic                          trdy_n,
  output logic                          stop_n,
  output logic                          devsel_n,
  output logic                          ctrl_oe_n,         // control drivers
  output logic                          ad_oe_n,           // data drivers
  output logic                          burst_trdy_n,      // registered burst ready
  output logic                          burst_trdy_async   // burst ready, comb
);

  import pci_bus_pkg::*;

  logic hb_write;     // 1 write, 0 read
  logic ad_oe_set;    // read start
  logic ad_oe_hold;   // read in progress

  assign hb_write         = hb_lcmd[cmd_write_bit];
  assign burst_trdy_async = ready_async && !stop_async;   // ready that continues a burst
  assign ad_oe_set        = !sobn_n && !cs_regs_n && !hb_write;

  ////////////////////////////////////////////////////////////////////////////
  // trdy, stop and burst ready
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      trdy_n       <= 1'b1;
      stop_n       <= 1'b1;
      burst_trdy_n <= 1'b1;
    end else begin
      trdy_n       <= !ready_async;
      stop_n       <= !(stop_async || (!stop_n && irdy_n));   // stop stays until irdy
      burst_trdy_n <= !burst_trdy_async;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // devsel and driver enables
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      devsel_n  <= 1'b1;
      ctrl_oe_n <= 1'b1;
    end else if (!sobn_n && !cs_regs_n) begin
      devsel_n  <= 1'b0;             // claim the cycle
      ctrl_oe_n <= 1'b0;
    end else if (last_phase) begin
      devsel_n  <= 1'b1;             // keep driving it high one more cycle
    end else if (!hb_cycle_done_n) begin
      ctrl_oe_n <= 1'b1;             // release after done
    end
  end

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      ad_oe_hold <= 1'b0;
      ad_oe_n    <= 1'b1;
    end else begin
      if (ad_oe_set) begin
        ad_oe_hold <= 1'b1;
      end else if (!hb_cycle_done_n) begin
        ad_oe_hold <= 1'b0;
      end
      ad_oe_n <= !(ad_oe_set || (ad_oe_hold && hb_cycle_done_n));   // off with ctrl_oe_n
    end
  end

endmodule

/* logic/addr_counter.sv */
// Internal address counter
`timescale 1ns/10ps

module addr_counter #(
  parameter int addr_w = hbi_target_pkg::addr_w_default
) (
  input  logic                          hb_clk,
  input  logic                          sys_reset_n,
  input  logic                          addr_strobe_n,      // address phase
  input  logic [addr_w-1:0]             hb_ad_bus,          // word address
  input  logic                          irdy_n,
  input  logic                          trdy_n,
  input  logic                          cs_regs_n,
  input  logic [pci_bus_pkg::cmd_w-1:0] hb_lcmd,
  input  logic                          burst_trdy_n,       // registered burst ready
  input  logic                          burst_trdy_async,   // burst ready, comb
  output logic [addr_w-1:0]             hbi_addr,           // current word address
  output logic                          wr_en               // register write strobe
);

  import pci_bus_pkg::*;

  logic hb_write;      // 1 write, 0 read
  logic data_strobe;   // write data phase on the bus
  logic write_incr;    // delayed write increment
  logic read_incr;     // advance ahead of read data

  assign hb_write    = hb_lcmd[cmd_write_bit];
  assign data_strobe = !irdy_n && !trdy_n && hb_write && !cs_regs_n;
  // first read ready, or next ready once the master took the data
  assign read_incr   = !hb_write && burst_trdy_async && (burst_trdy_n || !irdy_n);

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      write_incr <= 1'b0;
      wr_en      <= 1'b0;
    end else begin
      write_incr <= !irdy_n && !burst_trdy_n && hb_write;   // counts after wr_en
      wr_en      <= data_strobe;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word address
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      hbi_addr <= '0;
    end else if (!addr_strobe_n) begin
      hbi_addr <= hb_ad_bus;                       // load on address phase
    end else if (read_incr || write_incr) begin
      hbi_addr <= hbi_addr + addr_w'(1);           // next dword
    end
  end

endmodule

/* logic/hbi_target.sv */
// Host bus register target
`timescale 1ns/10ps

module hbi_target #(
  parameter int addr_w = hbi_target_pkg::addr_w_default
) (
  input  logic                              hb_clk,           // host bus clock
  input  logic                              sys_reset_n,      // pci reset pin
  input  logic                              frame_n,
  input  logic                              irdy_n,
  input  logic                              cs_regs_n,        // register space
  input  logic                              cs_engine_n,      // engine regs, retry on busy
  input  logic                              cs_kick_n,        // kick reg, disconnect
  input  logic                              engine_busy,
  input  logic [pci_bus_pkg::laddr_w-1:0]   hb_laddr,         // burst order
  input  logic [pci_bus_pkg::cmd_w-1:0]     hb_lcmd,          // latched command
  input  logic [addr_w-1:0]                 hb_ad_bus,        // word address bits
  output logic                              trdy_n,
  output logic                              stop_n,
  output logic                              devsel_n,
  output logic                              ctrl_oe_n,        // trdy/stop/devsel drivers
  output logic                              ad_oe_n,          // ad drivers
  output logic                              hb_cycle_done_n,
  output logic                              addr_strobe_n,
  output logic                              wr_en,
  output logic [addr_w-1:0]                 hbi_addr
);

  logic sobn_n;             // start of burst
  logic last_phase;         // final data phase
  logic ready_async;        // ready from fsm, unregistered
  logic stop_async;         // stop from fsm, unregistered
  logic burst_trdy_n;       // registered burst ready
  logic burst_trdy_async;   // unregistered burst ready

  bus_phase_detect phase_detect_inst (
    .hb_clk          (hb_clk),
    .sys_reset_n     (sys_reset_n),
    .frame_n         (frame_n),
    .irdy_n          (irdy_n),
    .trdy_n          (trdy_n),
    .stop_n          (stop_n),
    .addr_strobe_n   (addr_strobe_n),
    .sobn_n          (sobn_n),
    .last_phase      (last_phase),
    .hb_cycle_done_n (hb_cycle_done_n)
  );

  target_ready_fsm ready_fsm_inst (
    .hb_clk      (hb_clk),
    .sys_reset_n (sys_reset_n),
    .frame_n     (frame_n),
    .irdy_n      (irdy_n),
    .trdy_n      (trdy_n),
    .sobn_n      (sobn_n),
    .cs_regs_n   (cs_regs_n),
    .cs_engine_n (cs_engine_n),
    .cs_kick_n   (cs_kick_n),
    .engine_busy (engine_busy),
    .hb_laddr    (hb_laddr),
    .hb_lcmd     (hb_lcmd),
    .ready_async (ready_async),
    .stop_async  (stop_async)
  );

  bus_response response_inst (
    .hb_clk           (hb_clk),
    .sys_reset_n      (sys_reset_n),
    .sobn_n           (sobn_n),
    .last_phase       (last_phase),
    .hb_cycle_done_n  (hb_cycle_done_n),
    .cs_regs_n        (cs_regs_n),
    .ready_async      (ready_async),
    .stop_async       (stop_async),
    .irdy_n           (irdy_n),
    .hb_lcmd          (hb_lcmd),
    .trdy_n           (trdy_n),
    .stop_n           (stop_n),
    .devsel_n         (devsel_n),
    .ctrl_oe_n        (ctrl_oe_n),
    .ad_oe_n          (ad_oe_n),
    .burst_trdy_n     (burst_trdy_n),
    .burst_trdy_async (burst_trdy_async)
  );

  addr_counter #(
    .addr_w (addr_w)
  ) addr_counter_inst (
    .hb_clk           (hb_clk),
    .sys_reset_n      (sys_reset_n),
    .addr_strobe_n    (addr_strobe_n),
    .hb_ad_bus        (hb_ad_bus),
    .irdy_n           (irdy_n),
    .trdy_n           (trdy_n),
    .cs_regs_n        (cs_regs_n),
    .hb_lcmd          (hb_lcmd),
    .burst_trdy_n     (burst_trdy_n),
    .burst_trdy_async (burst_trdy_async),
    .hbi_addr         (hbi_addr),
    .wr_en            (wr_en)
  );

endmodule

/* verif/hbi_target_checker.sv */
// Bound bus protocol checks
`timescale 1ns/10ps

module hbi_target_checker (
  input logic hb_clk,
  input logic sys_reset_n,
  input logic frame_n,
  input logic trdy_n,
  input logic stop_n,
  input logic devsel_n,
  input logic ctrl_oe_n,
  input logic ad_oe_n,
  input logic wr_en
);

  int   assert_fail_count = 0;   // read back by the testbench
  logic frame_seen;              // frame has fallen since reset

  always_ff @(posedge hb_clk or negedge sys_reset_n) begin
    if (!sys_reset_n) begin
      frame_seen <= 1'b0;
    end else if (!frame_n) begin
      frame_seen <= 1'b1;          // first address phase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // target protocol
  ////////////////////////////////////////////////////////////////////////////

  strobe_needs_devsel: assert property (
    @(posedge hb_clk) disable iff (!sys_reset_n)
    devsel_n |-> (trdy_n && stop_n)                          // only while claimed
  ) else begin
    assert_fail_count++;
    $error("trdy_n or stop_n low while devsel_n is high");
  end

  wr_en_needs_trdy: assert property (
    @(posedge hb_clk) disable iff (!sys_reset_n)
    (wr_en && $past(wr_en)) |-> $past(!trdy_n && !ctrl_oe_n)   // burst on a driven bus
  ) else begin
    assert_fail_count++;
    $error("wr_en high two cycles in a row without trdy_n low on a driven bus");
  end

  quiet_until_frame: assert property (
    @(posedge hb_clk) disable iff (!sys_reset_n)
    !frame_seen |-> (trdy_n && stop_n && devsel_n && ctrl_oe_n && ad_oe_n && !wr_en)
  ) else begin
    assert_fail_count++;
    $error("target output active before the first address phase");
  end

endmodule

/* verif/tb_hbi_target.sv */
// Register target testbench
`timescale 1ns/10ps

module tb_hbi_target;

  import pci_bus_pkg::*;
  import hbi_target_pkg::*;

  localparam int addr_w       = addr_w_default;
  localparam int fields       = 12;   // words per trace line
  localparam int max_txn      = 32;
  localparam int reset_cycles = 8;

  logic               hb_clk;
  logic               sys_reset_n;
  logic               frame_n;
  logic               irdy_n;
  logic               cs_regs_n;
  logic               cs_engine_n;
  logic               cs_kick_n;
  logic               engine_busy;
  logic [laddr_w-1:0] hb_laddr;
  logic [cmd_w-1:0]   hb_lcmd;
  logic [addr_w-1:0]  hb_ad_bus;
  logic               trdy_n;
  logic               stop_n;
  logic               devsel_n;
  logic               ctrl_oe_n;
  logic               ad_oe_n;
  logic               hb_cycle_done_n;
  logic               addr_strobe_n;
  logic               wr_en;
  logic [addr_w-1:0]  hbi_addr;

  logic [31:0] trace_mem [0:fields*max_txn-1];   // whole trace, line by line
  int          error_count = 0;
  int          check_count = 0;
  int          other_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  logic        active;       // monitor window open
  logic        read_txn;
  logic [31:0] start_addr;
  string       txn_name;
  int          trdy_cnt;     // data phases taken with trdy
  int          wr_cnt;
  int          done_cnt;
  int          strobe_cnt;   // address strobes seen
  logic        stop_seen;

  hbi_target #(
    .addr_w (addr_w)
  ) hbi_target_inst (.*);

  bind hbi_target hbi_target_checker checker_inst (
    .hb_clk      (hb_clk),
    .sys_reset_n (sys_reset_n),
    .frame_n     (frame_n),
    .trdy_n      (trdy_n),
    .stop_n      (stop_n),
    .devsel_n    (devsel_n),
    .ctrl_oe_n   (ctrl_oe_n),
    .ad_oe_n     (ad_oe_n),
    .wr_en       (wr_en)
  );

  initial hb_clk = 1'b0;
  always #5 hb_clk = ~hb_clk;   // 10 ns period

  always @(posedge hb_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s expected %0h actual %0h", test_name, expected, actual);
    end
  endtask

  function automatic string kind_name(input logic [31:0] kind);
    case (kind)
      1:       return "write_burst";
      2:       return "engine_retry";
      3:       return "kick_disconnect";
      4:       return "read_burst";
      5:       return "burst_cut";
      default: return "unknown";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus monitor, sampled mid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge hb_clk) begin
    if (active) begin
      if (!addr_strobe_n) begin
        strobe_cnt++;                                   // frame falling edge
      end
      if (!trdy_n && !irdy_n) begin
        trdy_cnt++;                                     // phase taken with data
      end
      if (!stop_n) begin
        stop_seen = 1'b1;
      end
      if (!hb_cycle_done_n) begin
        done_cnt++;
      end
      if (wr_en) begin                                  // address of this data phase
        check_value({txn_name, " wr_en addr"}, addr_w'(start_addr + wr_cnt), hbi_addr);
        wr_cnt++;
      end
      if (read_txn && (!trdy_n || !hb_cycle_done_n)) begin
        check_value({txn_name, " ad_oe_n"}, 32'd0, ad_oe_n);   // data drivers on
      end else if (!read_txn) begin
        check_value({txn_name, " ad_oe_n"}, 32'd1, ad_oe_n);   // never on for writes
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // trace driven master
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_transaction(input int idx);
    int   base;
    int   phases;
    int   done_phases;
    logic t_smp;
    logic s_smp;
    logic finished;
    base       = idx * fields;
    phases     = trace_mem[base+4];
    txn_name   = $sformatf("%s_%0d", kind_name(trace_mem[base]), idx);
    start_addr = trace_mem[base+3];
    read_txn   = !trace_mem[base+1][cmd_write_bit];
    trdy_cnt   = 0;
    wr_cnt     = 0;
    done_cnt   = 0;
    strobe_cnt = 0;
    stop_seen  = 1'b0;
    @(posedge hb_clk);
    #1;
    active      = 1'b1;
    frame_n     = 1'b0;                                 // address phase
    irdy_n      = 1'b1;
    hb_lcmd     = trace_mem[base+1][cmd_w-1:0];
    hb_laddr    = trace_mem[base+2][laddr_w-1:0];
    hb_ad_bus   = trace_mem[base+3][addr_w-1:0];
    cs_regs_n   = trace_mem[base+5][0];
    cs_engine_n = trace_mem[base+6][0];
    cs_kick_n   = trace_mem[base+7][0];
    engine_busy = trace_mem[base+8][0];
    @(posedge hb_clk);
    #1;
    irdy_n      = 1'b0;
    frame_n     = (phases == 1);                        // single phase drops frame now
    done_phases = 0;
    finished    = 1'b0;
    while (!finished) begin
      @(negedge hb_clk);
      t_smp = trdy_n;
      s_smp = stop_n;
      @(posedge hb_clk);
      #1;
      if (!t_smp) begin
        done_phases++;
      end
      if (!t_smp || !s_smp) begin
        if (frame_n) begin
          irdy_n   = 1'b1;                              // final phase over
          finished = 1'b1;
        end else if (!s_smp || (done_phases == phases - 1)) begin
          frame_n = 1'b1;                               // irdy held for the last phase
        end
      end
    end
    cs_regs_n = 1'b1;
    repeat (3) @(posedge hb_clk);                       // let done pulse and enables settle
    #1;
    active = 1'b0;
    check_value({txn_name, " address strobes"}, 32'd1, strobe_cnt);
    check_value({txn_name, " trdy count"}, trace_mem[base+9], trdy_cnt);
    check_value({txn_name, " stop"}, trace_mem[base+10], stop_seen);
    check_value({txn_name, " wr_en count"}, trace_mem[base+11], wr_cnt);
    check_value({txn_name, " done pulses"}, 32'd1, done_cnt);
    check_value({txn_name, " devsel_n idle"}, 32'd1, devsel_n);
    check_value({txn_name, " ctrl_oe_n idle"}, 32'd1, ctrl_oe_n);
    check_value({txn_name, " ad_oe_n idle"}, 32'd1, ad_oe_n);
  endtask

  initial begin
    int n_txn;
    int assert_errors;
    sys_reset_n = 1'b0;
    frame_n     = 1'b1;
    irdy_n      = 1'b1;
    cs_regs_n   = 1'b1;
    cs_engine_n = 1'b1;
    cs_kick_n   = 1'b1;
    engine_busy = 1'b0;
    hb_laddr    = '0;
    hb_lcmd     = '0;
    hb_ad_bus   = '0;
    active      = 1'b0;
    $readmemh("verif/hbi_target_trace.txt", trace_mem);
    n_txn = 0;
    while ((n_txn < max_txn) && (trace_mem[n_txn*fields] > 0) &&
           (trace_mem[n_txn*fields] < 6)) begin
      cycle_limit += trace_mem[n_txn*fields+4] * 4 + 20;
      n_txn++;
    end
    cycle_limit += reset_cycles;
    if (n_txn == 0) begin
      other_count++;
      $display("the trace file holds no transactions");
    end
    repeat (reset_cycles) begin
      @(negedge hb_clk);
      check_value("reset trdy_n", 32'd1, trdy_n);
      check_value("reset stop_n", 32'd1, stop_n);
      check_value("reset devsel_n", 32'd1, devsel_n);
      check_value("reset ctrl_oe_n", 32'd1, ctrl_oe_n);
      check_value("reset ad_oe_n", 32'd1, ad_oe_n);
      check_value("reset wr_en", 32'd0, wr_en);
    end
    @(posedge hb_clk);
    #1;
    sys_reset_n = 1'b1;
    for (int i = 0; i < n_txn; i++) begin
      run_transaction(i);
    end
    assert_errors = hbi_target_inst.checker_inst.assert_fail_count;
    $display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
             check_count, error_count, other_count, assert_errors);
    if ((error_count + other_count + assert_errors) == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verif/hbi_target_trace.txt */
// kind cmd order start_addr phases cs_regs_n cs_engine_n cs_kick_n busy exp_trdy exp_stop exp_wr
// kind 1 write, 2 engine retry, 3 kick, 4 read, 5 reserved order or io burst, 0 ends the trace
1 7 0 00000100 4 0 1 1 0 4 0 4
1 7 0 00000200 1 0 1 1 0 1 0 1
1 7 0 3ffffffe 3 0 1 1 0 3 0 3
1 7 0 00000300 8 0 1 1 1 8 0 8
2 7 0 00000040 2 0 0 1 1 0 1 0
2 7 0 00000040 2 0 0 1 0 2 0 2
2 7 0 00000044 1 0 0 1 1 0 1 0
2 7 0 00000044 1 0 0 1 0 1 0 1
3 7 0 00000080 3 0 1 0 0 1 1 1
3 7 0 00000080 1 0 1 0 0 1 1 1
3 7 0 00000090 2 0 1 0 1 1 1 1
4 6 0 00000010 3 0 1 1 0 3 0 0
4 6 0 00000020 1 0 1 1 0 1 0 0
4 6 0 00000030 5 0 1 1 0 5 0 0
4 6 0 00000048 2 0 0 1 1 2 0 0
5 7 1 00000050 3 0 1 1 0 1 1 1
5 7 3 00000058 2 0 1 1 0 1 1 1
5 3 0 00000060 3 0 1 1 0 1 1 1
5 2 0 00000070 3 0 1 1 0 1 1 0
5 6 2 00000078 4 0 1 1 0 1 1 0
5 2 0 00000074 1 0 1 1 0 1 0 0
0 0 0 00000000 0 0 0 0 0 0 0 0

/* tb.f */
logic/pci_bus_pkg.sv
logic/hbi_target_pkg.sv
logic/bus_phase_detect.sv
logic/target_ready_fsm.sv
logic/bus_response.sv
logic/addr_counter.sv
logic/hbi_target.sv
verif/hbi_target_checker.sv
verif/tb_hbi_target.sv
